// File: list.f
hdl/stat_pkg.sv
hdl/sync_fifo.sv
hdl/ipv4_packet_counter.sv
hdl/sram_read_engine.sv
hdl/sram_stats_top.sv
testbench/tb_clock_gen.sv
testbench/tb_sram_stats.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass only if the pass line shows up
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_sram_stats -o tb_sram_stats

sim_out=$(./obj_dir/tb_sram_stats)
echo "$sim_out"

if grep -qx "TESTBENCH PASSED" <<< "$sim_out"; then
   exit 0
fi
exit 1

// File: testbench/tb_sram_stats.sv
// drives at 1 ns after the rising edge and samples at the falling edge; the seed is fixed
`timescale 1ns/1ps

module tb_sram_stats;

   logic                                   axi_aclk;
   logic                                   axi_aresetn;
   logic [stat_pkg::stream_data_width-1:0] s_axis_tdata;
   logic [stat_pkg::stream_strb_width-1:0] s_axis_tstrb;
   logic [stat_pkg::stream_user_width-1:0] s_axis_tuser;
   logic                                   s_axis_tvalid;
   logic                                   s_axis_tlast;
   logic                                   s_axis_tready;
   logic [stat_pkg::stream_data_width-1:0] m_axis_tdata;
   logic [stat_pkg::stream_strb_width-1:0] m_axis_tstrb;
   logic [stat_pkg::stream_user_width-1:0] m_axis_tuser;
   logic                                   m_axis_tvalid;
   logic                                   m_axis_tlast;
   logic                                   m_axis_tready;
   logic [stat_pkg::reg_width-1:0]         wo_regs;
   logic                                   write_valid;
   logic                                   read_busy;
   stat_pkg::ro_regs_t                     ro_regs;
   logic                                   sram_req_valid;
   logic [stat_pkg::sram_addr_width-1:0]   sram_req_addr;
   logic                                   sram_req_ready;
   logic                                   sram_rsp_valid;
   stat_pkg::sram_word_t                   sram_rsp_data;
   logic                                   sram_rsp_ready;

   stat_pkg::stream_beat_t               m_beat;
   stat_pkg::stream_beat_t               sent_q [$];   // accepted, not yet seen at the output
   stat_pkg::pkt_count_t                 exp_count;
   logic [stat_pkg::sram_addr_width-1:0] exp_addr;
   int  seed = 61;
   int  max_wait = 1000;  // cycles per wait loop
   int  beats_sent;
   int  beats_seen;
   int  reads_issued;
   int  req_count;
   int  beat_errors;
   int  addr_errors;
   int  ro_errors;
   int  other_errors;
   bit  sop_ref;
   bit  bp_on;

   assign m_beat = {m_axis_tlast, m_axis_tuser, m_axis_tstrb, m_axis_tdata};

   tb_clock_gen tb_clock_gen_i (
      .axi_aclk    (axi_aclk),
      .axi_aresetn (axi_aresetn)
   );

   sram_stats_top sram_stats_top_i (
      .axi_aclk       (axi_aclk),
      .axi_aresetn    (axi_aresetn),
      .s_axis_tdata   (s_axis_tdata),
      .s_axis_tstrb   (s_axis_tstrb),
      .s_axis_tuser   (s_axis_tuser),
      .s_axis_tvalid  (s_axis_tvalid),
      .s_axis_tlast   (s_axis_tlast),
      .s_axis_tready  (s_axis_tready),
      .m_axis_tdata   (m_axis_tdata),
      .m_axis_tstrb   (m_axis_tstrb),
      .m_axis_tuser   (m_axis_tuser),
      .m_axis_tvalid  (m_axis_tvalid),
      .m_axis_tlast   (m_axis_tlast),
      .m_axis_tready  (m_axis_tready),
      .wo_regs        (wo_regs),
      .write_valid    (write_valid),
      .read_busy      (read_busy),
      .ro_regs        (ro_regs),
      .sram_req_valid (sram_req_valid),
      .sram_req_addr  (sram_req_addr),
      .sram_req_ready (sram_req_ready),
      .sram_rsp_valid (sram_rsp_valid),
      .sram_rsp_data  (sram_rsp_data),
      .sram_rsp_ready (sram_rsp_ready)
   );

   // word n of address a, address and word index repeated across the word
   function automatic stat_pkg::sram_word_t sram_word_ref(
      input logic [stat_pkg::sram_addr_width-1:0] addr,
      input int                                   n
   );
      logic [23:0]  unit;
      logic [215:0] pat;
      unit = {addr ^ {19{n[0]}}, n[4:0]};
      pat  = {9{unit}};
      return pat[stat_pkg::sram_word_width-1:0];
   endfunction

   // word 0 on top, then word 1, zeros, count in the low word
   function automatic stat_pkg::ro_regs_t ro_ref(
      input logic [stat_pkg::sram_addr_width-1:0] addr,
      input stat_pkg::pkt_count_t                 count
   );
      stat_pkg::ro_regs_t ro;
      ro = '0;
      ro[$bits(stat_pkg::ro_regs_t)-1 -: stat_pkg::sram_word_width] = sram_word_ref(addr, 0);
      ro[$bits(stat_pkg::ro_regs_t)-1-stat_pkg::sram_word_width -: stat_pkg::sram_word_width] =
         sram_word_ref(addr, 1);
      ro[stat_pkg::reg_width-1:0] = count;
      return ro;
   endfunction

   // bytes 12 and 13, byte 12 is the high byte
   function automatic bit is_ipv4_start(input logic [stat_pkg::stream_data_width-1:0] tdata);
      return {tdata[12*8 +: 8], tdata[13*8 +: 8]} == 16'h0800;
   endfunction

   task automatic check_beat(input string name, input stat_pkg::stream_beat_t exp,
                             input stat_pkg::stream_beat_t act);
      if (act !== exp)
      begin
         beat_errors++;
         $display("FAIL %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_ro(input string name, input stat_pkg::ro_regs_t exp,
                           input stat_pkg::ro_regs_t act);
      if (act !== exp)
      begin
         ro_errors++;
         $display("FAIL %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_addr(input string name, input logic [stat_pkg::sram_addr_width-1:0] exp,
                             input logic [stat_pkg::sram_addr_width-1:0] act);
      if (act !== exp)
      begin
         addr_errors++;
         $display("FAIL %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   // kind 0 is IPv4, 1 another type, 2 another type with 0x0800 in later beats
   function automatic stat_pkg::stream_beat_t make_beat(input bit is_first, input int kind,
                                                         input bit last);
      stat_pkg::stream_beat_t beat;
      logic [15:0]            etype;
      for (int w = 0; w < 8; w++)
         beat.tdata[w*32 +: 32] = $random(seed);
      for (int w = 0; w < 4; w++)
         beat.tuser[w*32 +: 32] = $random(seed);
      beat.tstrb = $random(seed);
      beat.tlast = last;
      etype = {beat.tdata[12*8 +: 8], beat.tdata[13*8 +: 8]};
      if (is_first && kind == 0)
         etype = 16'h0800;
      else if (is_first)
         etype = (($random(seed) & 1) != 0) ? 16'h0008 : 16'h86dd; // 0x0008 is the swapped trap
      else if (kind == 2)
         etype = 16'h0800;
      beat.tdata[12*8 +: 8] = etype[15:8];
      beat.tdata[13*8 +: 8] = etype[7:0];
      return beat;
   endfunction

   task automatic send_beat(input stat_pkg::stream_beat_t beat);
      int cycles;
      bit taken;
      if (($random(seed) & 3) == 0)
      begin
         s_axis_tvalid = 1'b0; // idle cycle
         @(posedge axi_aclk);
         #1;
      end
      s_axis_tdata  = beat.tdata;
      s_axis_tstrb  = beat.tstrb;
      s_axis_tuser  = beat.tuser;
      s_axis_tlast  = beat.tlast;
      s_axis_tvalid = 1'b1;
      cycles = 0;
      taken  = 1'b0;
      while (!taken && cycles < max_wait)
      begin
         @(negedge axi_aclk);
         cycles++;
         taken = s_axis_tready;
         if (taken)
         begin
            sent_q.push_back(beat);
            beats_sent++;
            if (sop_ref && is_ipv4_start(beat.tdata))
               exp_count++;
            sop_ref = beat.tlast;
         end
         @(posedge axi_aclk);
         #1;
      end
      if (!taken)
      begin
         other_errors++;
         $display("ERROR: s_axis_tready stayed low for %0d cycles", max_wait);
      end
      s_axis_tvalid = 1'b0;
   endtask

   task automatic run_stream_phase(input int npkts);
      int kind;
      int nbeats;
      for (int p = 0; p < npkts; p++)
      begin
         kind   = ($random(seed) & 32'h7fffffff) % 3;
         nbeats = 1 + ($random(seed) & 3);
         for (int i = 0; i < nbeats; i++)
            send_beat(make_beat(i == 0, kind, i == nbeats - 1));
      end
   endtask

   task automatic wait_drain();
      int cycles;
      cycles = 0;
      while (sent_q.size() != 0 && cycles < max_wait)
      begin
         @(negedge axi_aclk);
         cycles++;
      end
      @(posedge axi_aclk);
      #1;
      if (sent_q.size() != 0)
      begin
         other_errors++;
         $display("ERROR: %0d beats never left the stream output", sent_q.size());
      end
      else if (beats_seen != beats_sent)
      begin
         other_errors++;
         $display("ERROR: %0d beats sent but %0d seen at the output", beats_sent, beats_seen);
      end
   endtask

   // random extra write_valid pulses only while read_busy, so each lands on a busy engine
   task automatic host_read(input logic [stat_pkg::reg_width-1:0] word);
      int cycles;
      bit done;
      exp_addr = word[stat_pkg::sram_addr_width-1:0];
      reads_issued++;
      wo_regs     = word;
      write_valid = 1'b1;
      @(posedge axi_aclk);
      #1;
      write_valid = 1'b0;
      wo_regs     = $random(seed);
      @(negedge axi_aclk);
      if (!read_busy || !sram_req_valid)
      begin
         other_errors++;
         $display("ERROR: read_busy or sram_req_valid did not rise after write_valid");
      end
      cycles = 0;
      done   = 1'b0;
      while (!done && cycles < max_wait)
      begin
         @(posedge axi_aclk);
         #1;
         write_valid = read_busy && (($random(seed) & 1) != 0);
         wo_regs     = $random(seed);
         @(negedge axi_aclk);
         cycles++;
         done = !read_busy;
      end
      if (!done)
      begin
         other_errors++;
         $display("ERROR: read_busy still high after %0d cycles", max_wait);
      end
      else
      begin
         check_ro("ro_regs after read", ro_ref(exp_addr, exp_count), ro_regs);
         if (req_count != reads_issued)
         begin
            other_errors++;
            $display("ERROR: %0d request handshakes for %0d reads", req_count, reads_issued);
         end
      end
      @(posedge axi_aclk);
      #1;
      write_valid = 1'b0;
   endtask

   task automatic check_reset_state();
      int cycles;
      bit in_reset;
      cycles   = 0;
      in_reset = 1'b1;
      while (in_reset && cycles < 10)
      begin
         @(negedge axi_aclk);
         cycles++;
         in_reset = !axi_aresetn;
         if (m_axis_tvalid || sram_req_valid || read_busy)
         begin
            other_errors++;
            $display("ERROR: DUT output active during or right after reset");
         end
         if (in_reset && (s_axis_tready || sram_rsp_ready))
         begin
            other_errors++;
            $display("ERROR: s_axis_tready or sram_rsp_ready high during reset");
         end
         check_ro("ro_regs in reset", '0, ro_regs);
      end
      if (in_reset)
      begin
         other_errors++;
         $display("ERROR: reset never released");
      end
   endtask

   task automatic final_report();
      int total;
      total = beat_errors + addr_errors + ro_errors + other_errors;
      $display("errors: beat %0d, address %0d, ro_regs %0d, other %0d",
               beat_errors, addr_errors, ro_errors, other_errors);
      if (total == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   endtask

   initial
   begin : main_sequence
      s_axis_tdata  = '0;
      s_axis_tstrb  = '0;
      s_axis_tuser  = '0;
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
      wo_regs       = '0;
      write_valid   = 1'b0;
      exp_count     = '0;
      exp_addr      = '0;
      sop_ref       = 1'b1; // first beat after reset opens a packet
      bp_on         = 1'b0;
      check_reset_state();
      @(posedge axi_aclk);
      #1;
      host_read($random(seed)); // count still zero
      bp_on = 1'b1;
      run_stream_phase(30);
      wait_drain();
      host_read($random(seed));
      bp_on = 1'b0;
      run_stream_phase(30);
      wait_drain();
      host_read($random(seed));
      host_read($random(seed));
      final_report();
   end

   initial
   begin : downstream_ready
      m_axis_tready = 1'b0;
      forever
      begin
         @(posedge axi_aclk);
         #1;
         m_axis_tready = bp_on ? (($random(seed) & 1) != 0) : 1'b1;
      end
   end

   // in-order compare of every beat taken at the output
   initial
   begin : stream_monitor
      forever
      begin
         @(negedge axi_aclk);
         if (axi_aresetn && m_axis_tvalid && m_axis_tready)
         begin
            beats_seen++;
            if (sent_q.size() == 0)
            begin
               beat_errors++;
               $display("ERROR: output beat with no input beat left to match");
            end
            else
               check_beat("stream beat", sent_q.pop_front(), m_beat);
         end
      end
   end

   // SRAM model, random ready on requests, two words per request with random gaps
   initial
   begin : sram_responder
      logic [stat_pkg::sram_addr_width-1:0] rsp_addr;
      int words_left;
      int word_idx;
      int gap;
      bit req_fire;
      bit rsp_fire;
      sram_req_ready = 1'b0;
      sram_rsp_valid = 1'b0;
      sram_rsp_data  = '0;
      rsp_addr       = '0;
      words_left     = 0;
      word_idx       = 0;
      gap            = 0;
      forever
      begin
         @(negedge axi_aclk);
         req_fire = sram_req_valid && sram_req_ready;
         rsp_fire = sram_rsp_valid && sram_rsp_ready;
         if (req_fire)
         begin
            req_count++;
            check_addr("sram request address", exp_addr, sram_req_addr);
            rsp_addr   = sram_req_addr;
            words_left = 2;
            word_idx   = 0;
            gap        = $random(seed) & 7;
         end
         if (rsp_fire)
         begin
            words_left--;
            word_idx++;
            gap = $random(seed) & 3;
         end
         @(posedge axi_aclk);
         #1;
         sram_req_ready = !req_fire && words_left == 0 && ($random(seed) % 3) == 0;
         if (words_left > 0 && gap == 0)
         begin
            sram_rsp_valid = 1'b1;
            sram_rsp_data  = sram_word_ref(rsp_addr, word_idx);
         end
         else
         begin
            sram_rsp_valid = 1'b0;
            if (gap > 0)
               gap--;
         end
      end
   end

endmodule

// File: testbench/tb_clock_gen.sv
// free-running 20 ns clock; reset held low through the first three rising edges
`timescale 1ns/1ps

module tb_clock_gen (
   output logic axi_aclk,
   output logic axi_aresetn
);

   initial
   begin
      axi_aclk = 1'b0;
      forever
         #10 axi_aclk = ~axi_aclk; // 20 ns period
   end

   initial
   begin
      axi_aresetn = 1'b0;
      repeat (3) @(posedge axi_aclk);
      #1 axi_aresetn = 1'b1; // released just after the third edge
   end

endmodule

// File: hdl/sram_stats_top.sv
// single clock; stream FIFO has four entries and drops tready with three held
`timescale 1ns/1ps

module sram_stats_top (
   input  logic                                   axi_aclk,
   input  logic                                   axi_aresetn,

   // upstream stream
   input  logic [stat_pkg::stream_data_width-1:0] s_axis_tdata,
   input  logic [stat_pkg::stream_strb_width-1:0] s_axis_tstrb,
   input  logic [stat_pkg::stream_user_width-1:0] s_axis_tuser,
   input  logic                                   s_axis_tvalid,
   input  logic                                   s_axis_tlast,
   output logic                                   s_axis_tready,

   // downstream stream
   output logic [stat_pkg::stream_data_width-1:0] m_axis_tdata,
   output logic [stat_pkg::stream_strb_width-1:0] m_axis_tstrb,
   output logic [stat_pkg::stream_user_width-1:0] m_axis_tuser,
   output logic                                   m_axis_tvalid,
   output logic                                   m_axis_tlast,
   input  logic                                   m_axis_tready,

   // host registers
   input  logic [stat_pkg::reg_width-1:0]         wo_regs,
   input  logic                                   write_valid,
   output logic                                   read_busy,
   output stat_pkg::ro_regs_t                     ro_regs,

   // SRAM request and response
   output logic                                   sram_req_valid,
   output logic [stat_pkg::sram_addr_width-1:0]   sram_req_addr,
   input  logic                                   sram_req_ready,
   input  logic                                   sram_rsp_valid,
   input  stat_pkg::sram_word_t                   sram_rsp_data,
   output logic                                   sram_rsp_ready
);

   stat_pkg::stream_beat_t in_beat;
   stat_pkg::stream_beat_t out_beat;
   stat_pkg::pkt_count_t   pkt_count;
   logic                   fifo_empty;
   logic                   fifo_nearly_full;
   logic                   fifo_rd_en;

   assign in_beat.tlast = s_axis_tlast;
   assign in_beat.tuser = s_axis_tuser;
   assign in_beat.tstrb = s_axis_tstrb;
   assign in_beat.tdata = s_axis_tdata;

   assign s_axis_tready = ~fifo_nearly_full; // keeps a spare slot
   assign m_axis_tvalid = ~fifo_empty;
   assign fifo_rd_en    = m_axis_tready & ~fifo_empty;

   assign m_axis_tlast = out_beat.tlast;
   assign m_axis_tuser = out_beat.tuser;
   assign m_axis_tstrb = out_beat.tstrb;
   assign m_axis_tdata = out_beat.tdata;

   sync_fifo #(
      .payload_t  (stat_pkg::stream_beat_t),
      .depth_bits (2)
   ) stream_fifo_i (
      .axi_aclk    (axi_aclk),
      .axi_aresetn (axi_aresetn),
      .din         (in_beat),
      .wr_en       (s_axis_tvalid & s_axis_tready),
      .rd_en       (fifo_rd_en),
      .dout        (out_beat),
      .empty       (fifo_empty),
      .full        (),
      .nearly_full (fifo_nearly_full)
   );

   // watches the input side, same handshake as the FIFO write
   ipv4_packet_counter ipv4_packet_counter_i (
      .axi_aclk      (axi_aclk),
      .axi_aresetn   (axi_aresetn),
      .s_axis_tdata  (s_axis_tdata),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .s_axis_tlast  (s_axis_tlast),
      .pkt_count     (pkt_count)
   );

   sram_read_engine sram_read_engine_i (
      .axi_aclk       (axi_aclk),
      .axi_aresetn    (axi_aresetn),
      .wo_regs        (wo_regs),
      .write_valid    (write_valid),
      .pkt_count      (pkt_count),
      .sram_req_ready (sram_req_ready),
      .sram_rsp_valid (sram_rsp_valid),
      .sram_rsp_data  (sram_rsp_data),
      .read_busy      (read_busy),
      .sram_req_valid (sram_req_valid),
      .sram_req_addr  (sram_req_addr),
      .sram_rsp_ready (sram_rsp_ready),
      .ro_regs        (ro_regs)
   );

endmodule

// File: hdl/sram_read_engine.sv
// one read of two words per host write; writes while busy are dropped, words must return in order
`timescale 1ns/1ps

module sram_read_engine (
   input  logic                                 axi_aclk,
   input  logic                                 axi_aresetn,
   input  logic [stat_pkg::reg_width-1:0]       wo_regs,
   input  logic                                 write_valid,
   input  stat_pkg::pkt_count_t                 pkt_count,
   input  logic                                 sram_req_ready,
   input  logic                                 sram_rsp_valid,
   input  stat_pkg::sram_word_t                 sram_rsp_data,
   output logic                                 read_busy,
   output logic                                 sram_req_valid,
   output logic [stat_pkg::sram_addr_width-1:0] sram_req_addr,
   output logic                                 sram_rsp_ready,
   output stat_pkg::ro_regs_t                   ro_regs
);

   typedef enum logic [1:0] {
      IDLE    = 2'd0,
      REQUEST = 2'd1,
      WAIT_0  = 2'd2,
      WAIT_1  = 2'd3
   } state_t;

   state_t               state;
   state_t               next_state;
   stat_pkg::sram_word_t rsp_word;
   stat_pkg::sram_word_t first_word; // held until the second word shows up
   logic                 rsp_empty;
   logic                 rsp_full;
   logic                 rsp_pop;
   logic                 waiting;

   // response buffer, two entries
   sync_fifo #(
      .payload_t  (stat_pkg::sram_word_t),
      .depth_bits (1)
   ) rsp_fifo_i (
      .axi_aclk    (axi_aclk),
      .axi_aresetn (axi_aresetn),
      .din         (sram_rsp_data),
      .wr_en       (sram_rsp_valid),
      .rd_en       (rsp_pop),
      .dout        (rsp_word),
      .empty       (rsp_empty),
      .full        (rsp_full),
      .nearly_full ()
   );

   assign sram_rsp_ready = ~rsp_full;

   assign waiting        = (state == WAIT_0) || (state == WAIT_1);
   assign rsp_pop        = waiting & ~rsp_empty; // one word per wait state
   assign read_busy      = (state != IDLE);
   assign sram_req_valid = (state == REQUEST);

   always_comb
   begin
      next_state = state;
      case (state)
         IDLE:
         begin
            if (write_valid)
               next_state = REQUEST;
         end
         REQUEST:
         begin
            if (sram_req_ready)
               next_state = WAIT_0; // handshake done
         end
         WAIT_0:
         begin
            if (rsp_pop)
               next_state = WAIT_1;
         end
         WAIT_1:
         begin
            if (rsp_pop)
               next_state = IDLE;
         end
         default: next_state = IDLE;
      endcase
   end

   always_ff @(posedge axi_aclk or negedge axi_aresetn)
   begin
      if (!axi_aresetn)
         state <= IDLE;
      else
         state <= next_state;
   end

   // address stays put through the request phase
   always_ff @(posedge axi_aclk)
   begin
      if (state == IDLE && write_valid)
         sram_req_addr <= wo_regs[stat_pkg::sram_addr_width-1:0];
   end

   always_ff @(posedge axi_aclk)
   begin
      if (state == WAIT_0 && rsp_pop)
         first_word <= rsp_word;
   end

   // result bank, loaded with the second pop
   always_ff @(posedge axi_aclk or negedge axi_aresetn)
   begin
      if (!axi_aresetn)
      begin
         ro_regs <= '0;
      end
      else if (state == WAIT_1 && rsp_pop)
      begin
         ro_regs <= {first_word, rsp_word, {stat_pkg::ro_pad_width{1'b0}}, pkt_count};
      end
   end

endmodule

// File: hdl/ipv4_packet_counter.sv
// counts packets whose first beat carries ethertype 0x0800; only accepted beats are looked at
`timescale 1ns/1ps

module ipv4_packet_counter (
   input  logic                                   axi_aclk,
   input  logic                                   axi_aresetn,
   input  logic [stat_pkg::stream_data_width-1:0] s_axis_tdata,
   input  logic                                   s_axis_tvalid,
   input  logic                                   s_axis_tready,
   input  logic                                   s_axis_tlast,
   output stat_pkg::pkt_count_t                   pkt_count
);

   logic        beat_ok;
   logic        sop;        // next accepted beat opens a packet
   logic [15:0] ether_type;
   logic        is_ipv4;

   assign beat_ok = s_axis_tvalid & s_axis_tready;

   // network order, lower byte address is the high byte
   assign ether_type = {s_axis_tdata[stat_pkg::ethertype_lsb +: 8],
                        s_axis_tdata[stat_pkg::ethertype_lsb + 8 +: 8]};

   assign is_ipv4 = (ether_type == stat_pkg::ethertype_ipv4);

   always_ff @(posedge axi_aclk or negedge axi_aresetn)
   begin
      if (!axi_aresetn)
         sop <= 1'b1;           // first beat after reset starts a packet
      else if (beat_ok)
         sop <= s_axis_tlast;
   end

   // later beats of a packet never count, whatever they hold
   always_ff @(posedge axi_aclk or negedge axi_aresetn)
   begin
      if (!axi_aresetn)
      begin
         pkt_count <= '0;
      end
      else if (beat_ok && sop && is_ipv4)
      begin
         pkt_count <= pkt_count + 1'b1; // wraps
      end
   end

endmodule

// File: hdl/sync_fifo.sv
// fwft FIFO of 2**depth_bits entries; full and nearly_full stay high until one clock after reset
`timescale 1ns/1ps

module sync_fifo #(
   parameter type payload_t  = logic,
   parameter int  depth_bits = 2
) (
   input  logic     axi_aclk,
   input  logic     axi_aresetn,
   input  payload_t din,
   input  logic     wr_en,
   input  logic     rd_en,
   output payload_t dout,
   output logic     empty,
   output logic     full,
   output logic     nearly_full
);

   payload_t mem [2**depth_bits];

   logic [depth_bits-1:0] wr_ptr;
   logic [depth_bits-1:0] rd_ptr;
   logic [depth_bits:0]   count;    // 0 .. 2**depth_bits
   logic                  init_done;
   logic                  wr_ok;
   logic                  rd_ok;

   assign wr_ok = wr_en & ~full;  // writes into a full FIFO are dropped
   assign rd_ok = rd_en & ~empty;

   assign dout        = mem[rd_ptr]; // head entry always visible
   assign empty       = (count == '0);
   assign full        = ~init_done | count[depth_bits];
   // one free slot left, or none
   assign nearly_full = ~init_done | count[depth_bits] | (&count[depth_bits-1:0]);

   always_ff @(posedge axi_aclk or negedge axi_aresetn)
   begin
      if (!axi_aresetn)
      begin
         init_done <= 1'b0;
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
      end
      else
      begin
         init_done <= 1'b1;
         if (wr_ok)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_ok)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr_ok, rd_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count; // both or neither
         endcase
      end
   end

   // storage only
   always_ff @(posedge axi_aclk)
   begin
      if (wr_ok)
         mem[wr_ptr] <= din;
   end

endmodule

// File: hdl/stat_pkg.sv
// fixed to a 256-bit stream and 201-bit SRAM words; the result bank must fit two words plus count
package stat_pkg;

   // stream widths
   localparam int stream_data_width = 256;
   localparam int stream_user_width = 128;
   localparam int stream_strb_width = stream_data_width / 8; // one strobe per byte

   // host register bank
   localparam int reg_width   = 32;
   localparam int num_ro_regs = 16;

   // external SRAM port
   localparam int sram_addr_width = 19;
   localparam int sram_word_width = 201;

   // ethertype sits in bytes 12 and 13, byte 12 at bit 96 is the high byte
   localparam logic [15:0] ethertype_ipv4 = 16'h0800;
   localparam int          ethertype_lsb  = 96;

   // zero fill between the second SRAM word and the packet count
   localparam int ro_pad_width = reg_width * num_ro_regs - 2 * sram_word_width - reg_width;

   typedef logic [sram_word_width-1:0] sram_word_t;

   typedef logic [reg_width-1:0] pkt_count_t; // wraps at 2^32

   // {word 0, word 1, pad, count} from msb down
   typedef logic [reg_width*num_ro_regs-1:0] ro_regs_t;

   // one stream beat as it sits in the pass-through FIFO
   typedef struct packed {
      logic                         tlast;
      logic [stream_user_width-1:0] tuser;
      logic [stream_strb_width-1:0] tstrb;
      logic [stream_data_width-1:0] tdata;
   } stream_beat_t;

endpackage
